// File: hw/pipe_pkg.sv
// pipe_pkg: shared types for the rv32i pipeline-control slice

package pipe_pkg;

    localparam int regidx_w = 5;                // x0..x31

    typedef logic [31:0]         word_t;        // data word or byte address
    typedef logic [regidx_w-1:0] regidx_t;

    // decoded operations, everything else lands on op_illegal
    typedef enum logic [3:0] {
        op_addi,
        op_add,
        op_sub,
        op_lw,
        op_sw,
        op_beq,
        op_bne,
        op_jal,
        op_illegal
    } opcode_e;

    // fetched word and its address, fetch -> queue -> execute
    typedef struct packed {
        word_t pc;
        word_t insn;
    } fetch_pkt_t;

    // execute stage view for the hazard unit
    typedef struct packed {
        logic    valid_e;
        regidx_t rs1_e;
        regidx_t rs2_e;
        word_t   pc_e;
        logic    redirect;                      // taken branch or jal
        logic    illegal;                       // undecodable word in execute
        word_t   target;                        // branch or jump destination
    } exec_status_t;

    // memory stage view for the hazard unit
    typedef struct packed {
        logic    valid_m;
        regidx_t rd_m;
        logic    reg_write;
        logic    is_load;
        logic    dmem_access;                   // load or store pending
        word_t   pc_m;
    } mem_status_t;

    // stall/flush/redirect decisions, one cycle at a time
    typedef struct packed {
        logic  pc_en;
        logic  npc_sel;                         // take branch/jump target
        logic  trap;                            // take trap vector
        logic  fetch_flush;                     // drop the word fetched this cycle
        logic  stall_queue;
        logic  flush_queue;
        logic  ex_mem_stall;
        logic  ex_mem_flush;                    // bubble into memory stage
        word_t redirect_pc;
    } hazard_ctrl_t;

    // one retired instruction
    typedef struct packed {
        logic    valid;
        word_t   pc;
        regidx_t rd;
        word_t   wdata;
        logic    has_write;
        logic    exception;
        word_t   epc;
    } commit_t;

endpackage

// File: hw/fetch_stage.sv
// fetch_stage: keeps the pc, requests instruction words and hands them to the queue
`timescale 1ns/10ps

module fetch_stage
    import pipe_pkg::*;
#(
    parameter word_t reset_pc = 32'h0000_0000
) (
    input  logic         CLK,
    input  logic         rst_n,
    input  hazard_ctrl_t ctrl,
    input  logic         imem_busy,
    input  word_t        imem_rdata,
    output logic         imem_ren,
    output word_t        imem_addr,
    output logic         push,
    output fetch_pkt_t   push_pkt
);

    word_t      pc;
    logic       active;                         // low until the first edge out of reset
    logic       accept;                         // word handed over this cycle
    logic       resp_valid;                     // captured word waiting to be pushed
    logic       discard;                        // captured word is wrong-path
    fetch_pkt_t resp_pkt;

    // no request while halted or while the queue cannot take more
    assign imem_ren  = active && ctrl.pc_en;
    assign imem_addr = pc;
    assign accept    = imem_ren && !imem_busy;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            pc         <= reset_pc;
            active     <= 1'b0;
            resp_valid <= 1'b0;
            discard    <= 1'b0;
        end else begin
            active     <= 1'b1;
            resp_valid <= accept;
            discard    <= ctrl.fetch_flush;     // word accepted alongside a redirect
            if (ctrl.trap || ctrl.npc_sel) begin
                pc <= ctrl.redirect_pc;         // redirect beats sequential fetch
            end else if (accept) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // response capture, pushed on the following edge
    always_ff @(posedge CLK) begin
        if (accept) begin
            resp_pkt.pc   <= pc;
            resp_pkt.insn <= imem_rdata;
        end
    end

    assign push     = resp_valid && !discard;
    assign push_pkt = resp_pkt;

endmodule

// File: hw/insn_queue.sv
// insn_queue: circular fifo of fetched instructions between fetch and execute
`timescale 1ns/10ps

module insn_queue
    import pipe_pkg::*;
#(
    parameter int queue_depth = 4
) (
    input  logic       CLK,
    input  logic       rst_n,
    input  logic       push,
    input  fetch_pkt_t push_pkt,
    input  logic       pop,
    input  logic       flush,
    output fetch_pkt_t head,
    output logic       not_empty,
    output logic       full
);

    localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w = $clog2(queue_depth + 1);

    fetch_pkt_t       entries [queue_depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic             wr_en;
    logic             rd_en;

    // wrap explicitly so any depth works, not only powers of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(queue_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign not_empty = (count != '0);
    assign head      = entries[rd_ptr];

    // fetch pushes one edge after acceptance, so count the pending push too
    assign full = (count == cnt_w'(queue_depth))
               || (push && count == cnt_w'(queue_depth - 1));

    assign wr_en = push && !flush && (count != cnt_w'(queue_depth));
    assign rd_en = pop && not_empty && !flush;

    always_ff @(posedge CLK) begin
        if (!rst_n || flush) begin              // flush drops a same-cycle push
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= next_ptr(wr_ptr);
            if (rd_en) rd_ptr <= next_ptr(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_en) entries[wr_ptr] <= push_pkt;
    end

endmodule

// File: hw/exec_mem_stage.sv
// exec_mem_stage: decode, regfile, alu with forwarding, branch resolve, data access, retire
`timescale 1ns/10ps

module exec_mem_stage
    import pipe_pkg::*;
(
    input  logic         CLK,
    input  logic         rst_n,
    input  hazard_ctrl_t ctrl,
    input  fetch_pkt_t   head,
    input  logic         not_empty,
    output logic         pop,
    input  logic         dmem_busy,
    input  word_t        dmem_rdata,
    output logic         dmem_ren,
    output logic         dmem_wen,
    output word_t        dmem_addr,
    output word_t        dmem_wdata,
    output exec_status_t ex_status,
    output mem_status_t  mem_status,
    output commit_t      commit
);

    word_t      rf [2**regidx_w];               // x0 never written, read as zero
    logic       valid_e;
    fetch_pkt_t pkt_e;
    opcode_e    op_e;
    logic [2:0] funct3;
    logic [6:0] funct7;
    regidx_t    rs1_e;
    regidx_t    rs2_e;
    regidx_t    rd_e;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    logic       fwd1;
    logic       fwd2;
    word_t      src1;
    word_t      src2;
    word_t      alu_e;
    word_t      target_e;
    logic       taken_e;
    logic       valid_m;
    opcode_e    op_m;
    regidx_t    rd_m;
    word_t      result_m;                       // alu result or load/store address
    word_t      store_m;
    word_t      pc_m;
    logic       reg_write_m;
    logic       is_load_m;
    logic       is_store_m;
    logic       has_write_m;
    logic       m_done;                         // memory stage retires this cycle
    word_t      wb_data;
    logic       commit_valid;
    word_t      c_pc;
    regidx_t    c_rd;
    word_t      c_wdata;
    logic       c_has_write;
    logic       c_exception;

    assign funct3 = pkt_e.insn[14:12];
    assign funct7 = pkt_e.insn[31:25];
    assign rs1_e  = pkt_e.insn[19:15];
    assign rs2_e  = pkt_e.insn[24:20];
    assign rd_e   = pkt_e.insn[11:7];
    assign imm_i  = {{20{pkt_e.insn[31]}}, pkt_e.insn[31:20]};
    assign imm_s  = {{20{pkt_e.insn[31]}}, pkt_e.insn[31:25], pkt_e.insn[11:7]};
    assign imm_b  = {{19{pkt_e.insn[31]}}, pkt_e.insn[31], pkt_e.insn[7],
                     pkt_e.insn[30:25], pkt_e.insn[11:8], 1'b0};
    assign imm_j  = {{11{pkt_e.insn[31]}}, pkt_e.insn[31], pkt_e.insn[19:12],
                     pkt_e.insn[20], pkt_e.insn[30:21], 1'b0};

    // decode, anything outside the subset is illegal
    always_comb begin
        op_e = op_illegal;
        case (pkt_e.insn[6:0])
            7'b0010011: if (funct3 == 3'b000) op_e = op_addi;
            7'b0110011: begin                   // register-register
                if (funct3 == 3'b000 && funct7 == 7'b0000000) op_e = op_add;
                else if (funct3 == 3'b000 && funct7 == 7'b0100000) op_e = op_sub;
            end
            7'b0000011: if (funct3 == 3'b010) op_e = op_lw;
            7'b0100011: if (funct3 == 3'b010) op_e = op_sw;
            7'b1100011: begin
                if (funct3 == 3'b000) op_e = op_beq;
                else if (funct3 == 3'b001) op_e = op_bne;
            end
            7'b1101111: op_e = op_jal;
            default:    op_e = op_illegal;
        endcase
    end

    // loads are not forwarded, the hazard unit stalls for those
    assign fwd1 = valid_m && reg_write_m && !is_load_m && rd_m != '0 && rd_m == rs1_e;
    assign fwd2 = valid_m && reg_write_m && !is_load_m && rd_m != '0 && rd_m == rs2_e;
    assign src1 = fwd1 ? result_m : ((rs1_e == '0) ? '0 : rf[rs1_e]);
    assign src2 = fwd2 ? result_m : ((rs2_e == '0) ? '0 : rf[rs2_e]);

    always_comb begin
        alu_e    = src1 + imm_i;                // addi, lw address
        taken_e  = 1'b0;
        target_e = pkt_e.pc + imm_b;
        case (op_e)
            op_add: alu_e = src1 + src2;
            op_sub: alu_e = src1 - src2;
            op_sw:  alu_e = src1 + imm_s;
            op_beq: taken_e = (src1 == src2);
            op_bne: taken_e = (src1 != src2);
            op_jal: begin
                alu_e    = pkt_e.pc + 32'd4;    // link value
                taken_e  = 1'b1;
                target_e = pkt_e.pc + imm_j;
            end
            default: ;
        endcase
    end

    assign ex_status = '{valid_e: valid_e, rs1_e: rs1_e, rs2_e: rs2_e, pc_e: pkt_e.pc,
                         redirect: valid_e && taken_e,
                         illegal: valid_e && (op_e == op_illegal), target: target_e};

    // take the head only when execute is free to move on
    assign pop = not_empty && !ctrl.stall_queue && !ctrl.flush_queue;

    assign reg_write_m = op_m inside {op_addi, op_add, op_sub, op_lw, op_jal};
    assign is_load_m   = (op_m == op_lw);
    assign is_store_m  = (op_m == op_sw);
    assign has_write_m = reg_write_m && rd_m != '0;
    assign dmem_ren    = valid_m && is_load_m;
    assign dmem_wen    = valid_m && is_store_m;
    assign dmem_addr   = result_m;
    assign dmem_wdata  = store_m;
    assign mem_status  = '{valid_m: valid_m, rd_m: rd_m, reg_write: reg_write_m,
                          is_load: is_load_m, dmem_access: is_load_m || is_store_m, pc_m: pc_m};
    assign m_done      = valid_m && !ctrl.ex_mem_stall;   // stall covers a busy dmem
    assign wb_data     = is_load_m ? dmem_rdata : result_m;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            valid_e      <= 1'b0;
            valid_m      <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= m_done;
            if (!ctrl.ex_mem_stall) begin
                valid_m <= valid_e && !ctrl.ex_mem_flush;   // bubble on load-use
                if (ctrl.flush_queue) valid_e <= 1'b0;      // redirecting insn moves on
                else if (!ctrl.stall_queue) valid_e <= not_empty;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (pop) pkt_e <= head;
        if (!ctrl.ex_mem_stall) begin
            op_m     <= op_e;
            rd_m     <= rd_e;
            result_m <= alu_e;
            store_m  <= src2;
            pc_m     <= pkt_e.pc;
        end
        if (m_done) begin
            c_pc        <= pc_m;
            c_rd        <= has_write_m ? rd_m : '0;
            c_wdata     <= has_write_m ? wb_data : '0;
            c_has_write <= has_write_m;
            c_exception <= (op_m == op_illegal);
        end
        if (m_done && has_write_m) rf[rd_m] <= wb_data;
    end

    // epc filled in at the top from the hazard unit
    assign commit = '{valid: commit_valid, pc: c_pc, rd: c_rd, wdata: c_wdata,
                      has_write: c_has_write, exception: c_exception, epc: '0};

endmodule

// File: hw/hazard_unit.sv
// hazard unit that drives combinational stall, flush and redirect control for fetch, queue and execute
`timescale 1ns/10ps

module hazard_unit
    import pipe_pkg::*;
#(
    parameter word_t trap_vector = 32'h0000_0100
) (
    input  logic         full,
    input  logic         imem_busy,
    input  logic         dmem_busy,
    input  logic         halt,
    input  exec_status_t ex_status,
    input  mem_status_t  mem_status,
    output hazard_ctrl_t ctrl,
    output word_t        epc
);

    logic rs1_match;
    logic rs2_match;
    logic wait_for_dmem;
    logic mem_use_stall;
    logic ex_mem_stall;
    logic stall_queue;
    logic branch_jump;
    logic exception;
    logic flush_queue;

    // load result in mem needed by execute
    assign rs1_match = (ex_status.rs1_e == mem_status.rd_m) && (mem_status.rd_m != '0);
    assign rs2_match = (ex_status.rs2_e == mem_status.rd_m) && (mem_status.rd_m != '0);
    assign mem_use_stall = mem_status.valid_m && mem_status.is_load && mem_status.reg_write
                        && ex_status.valid_e && (rs1_match || rs2_match);

    assign wait_for_dmem = mem_status.valid_m && mem_status.dmem_access && dmem_busy;

    // later stage stalled -> earlier stage stalled
    assign ex_mem_stall = wait_for_dmem || halt;
    assign stall_queue  = ex_mem_stall || mem_use_stall;

    // control hazards only act once execute can actually move
    assign branch_jump = ex_status.valid_e && ex_status.redirect && !stall_queue;
    assign exception   = ex_status.valid_e && ex_status.illegal && !stall_queue;
    assign flush_queue = branch_jump || exception;

    always_comb begin
        ctrl.pc_en        = (!full && !halt) || branch_jump || exception;
        ctrl.npc_sel      = branch_jump;
        ctrl.trap         = exception;
        ctrl.fetch_flush  = flush_queue && !imem_busy;   // a wrong-path word got accepted
        ctrl.stall_queue  = stall_queue;
        ctrl.flush_queue  = flush_queue;
        ctrl.ex_mem_stall = ex_mem_stall;
        ctrl.ex_mem_flush = stall_queue && !ex_mem_stall; // only the load-use bubble
        if (exception) begin
            ctrl.redirect_pc = trap_vector;
        end else if (branch_jump) begin
            ctrl.redirect_pc = ex_status.target;
        end else begin
            ctrl.redirect_pc = '0;
        end
    end

    // oldest valid insn first and otherwise the last pc seen in execute
    assign epc = mem_status.valid_m ? mem_status.pc_m : ex_status.pc_e;

endmodule

// File: hw/rv_pipe_top.sv
// rv_pipe_top: fetch, instruction queue, execute/memory and hazard control wired together
`timescale 1ns/10ps

module rv_pipe_top
    import pipe_pkg::*;
#(
    parameter int    queue_depth = 4,
    parameter word_t reset_pc    = 32'h0000_0000,
    parameter word_t trap_vector = 32'h0000_0100
) (
    input  logic    CLK,
    input  logic    rst_n,
    input  logic    halt,
    output logic    imem_ren,
    output word_t   imem_addr,
    input  logic    imem_busy,
    input  word_t   imem_rdata,
    output logic    dmem_ren,
    output logic    dmem_wen,
    output word_t   dmem_addr,
    output word_t   dmem_wdata,
    input  logic    dmem_busy,
    input  word_t   dmem_rdata,
    output commit_t commit
);

    hazard_ctrl_t ctrl;
    fetch_pkt_t   push_pkt;
    fetch_pkt_t   head;
    logic         push;
    logic         pop;
    logic         full;
    logic         not_empty;
    exec_status_t ex_status;
    mem_status_t  mem_status;
    commit_t      core_commit;
    word_t        epc;

    fetch_stage #(.reset_pc(reset_pc)) fetch_i (
        .CLK, .rst_n, .ctrl, .imem_busy, .imem_rdata,
        .imem_ren, .imem_addr, .push, .push_pkt
    );

    insn_queue #(.queue_depth(queue_depth)) queue_i (
        .CLK, .rst_n, .push, .push_pkt, .pop, .flush(ctrl.flush_queue),
        .head, .not_empty, .full
    );

    exec_mem_stage exec_i (
        .CLK, .rst_n, .ctrl, .head, .not_empty, .pop, .dmem_busy, .dmem_rdata,
        .dmem_ren, .dmem_wen, .dmem_addr, .dmem_wdata, .ex_status, .mem_status,
        .commit(core_commit)
    );

    hazard_unit #(.trap_vector(trap_vector)) hazard_i (
        .full, .imem_busy, .dmem_busy, .halt, .ex_status, .mem_status, .ctrl, .epc
    );

    // epc is sampled while the trapping insn's commit is visible
    always_comb begin
        commit     = core_commit;
        commit.epc = core_commit.exception ? epc : '0;
    end

endmodule

// File: test/rv_pipe_tb.sv
// pipeline testbench that replays the golden program and checks every retirement
`timescale 1ns/10ps

module rv_pipe_tb
    import pipe_pkg::*;
();

    localparam int commit_timeout = 200;        // cycles allowed between two retirements
    localparam int halt_timeout   = 2000;

    // one expected retirement as read from the trace
    typedef struct packed {
        logic [127:0] name;                     // test name of up to 16 characters
        word_t        pc;
        regidx_t      rd;
        word_t        wdata;
        logic         has_write;
        logic         exception;
    } expect_t;

    logic    CLK;
    logic    rst_n;
    logic    halt;
    logic    imem_ren;
    word_t   imem_addr;
    logic    imem_busy;
    word_t   imem_rdata;
    logic    dmem_ren;
    logic    dmem_wen;
    word_t   dmem_addr;
    word_t   dmem_wdata;
    logic    dmem_busy;
    word_t   dmem_rdata;
    commit_t commit;

    word_t   imem [256];                        // 1 KiB program space
    word_t   dmem [64];
    expect_t golden [$];
    int      rec_idx;                           // next golden record to match
    int      errors;
    int      checks;
    int      halt_cycles;
    logic    halt_prev;                         // halt level one cycle back

    rv_pipe_top #(
        .queue_depth(4),
        .reset_pc(32'h0000_0000),
        .trap_vector(32'h0000_0100)
    ) rv_pipe_top_i (
        .CLK, .rst_n, .halt, .imem_ren, .imem_addr, .imem_busy, .imem_rdata,
        .dmem_ren, .dmem_wen, .dmem_addr, .dmem_wdata, .dmem_busy, .dmem_rdata, .commit
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;                 // 50 MHz
    end

    // memory models with asynchronous reads and random busy levels
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge CLK) begin
        imem_busy <= ($urandom % 4) == 0;       // roughly one cycle in four
        dmem_busy <= ($urandom % 2) == 0;       // heavier back-pressure on data
        if (dmem_wen && !dmem_busy) dmem[dmem_addr[7:2]] <= dmem_wdata;   // store completes
    end

    // nothing may retire in a cycle that follows a halted one
    always @(negedge CLK) begin
        if (rst_n && halt_prev && commit.valid) begin
            $display("instruction at pc %h retired while halt was held", commit.pc);
            errors++;
        end
        if (halt) halt_cycles++;
        halt_prev = halt;
    end

    function automatic bit halt_due();
        return rec_idx < golden.size() && golden[rec_idx].name == "halt_freeze";
    endfunction

    task automatic load_golden();
        int           fd;
        int           n;
        int           rd;
        int           hw;
        int           ex;
        bit           bad;
        string        line;
        logic [127:0] name;
        word_t        addr;
        word_t        word;
        word_t        pc;
        word_t        wdata;
        expect_t      rec;
        fd = $fopen("test/golden_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/golden_trace.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n <= 0) continue;
            bad = 1'b0;
            if (line[0] == "I") begin           // program word
                n = $sscanf(line, "I %h %h", addr, word);
                if (n == 2) imem[addr[9:2]] = word;
                else bad = 1'b1;
            end else if (line[0] == "C") begin  // expected commit
                n = $sscanf(line, "C %s %h %d %h %d %d", name, pc, rd, wdata, hw, ex);
                rec = '{name: name, pc: pc, rd: rd[4:0], wdata: wdata,
                        has_write: hw[0], exception: ex[0]};
                if (n == 6) golden.push_back(rec);
                else bad = 1'b1;
            end
            if (bad) begin
                $display("malformed line in golden trace: %s", line);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic report_mismatch(input logic [127:0] test, input string field,
                                   input word_t exp_val, input word_t act_val);
        $display("error %0s %0s: expected %h, actual %h", test, field, exp_val, act_val);
        errors++;
    endtask

    // field by field against the next golden record
    task automatic compare_commit(input expect_t e);
        checks++;
        if (commit.pc !== e.pc) report_mismatch(e.name, "pc", e.pc, commit.pc);
        if (commit.rd !== e.rd) report_mismatch(e.name, "rd", word_t'(e.rd), word_t'(commit.rd));
        if (commit.wdata !== e.wdata) report_mismatch(e.name, "wdata", e.wdata, commit.wdata);
        if (commit.has_write !== e.has_write)
            report_mismatch(e.name, "has_write", word_t'(e.has_write), word_t'(commit.has_write));
        if (commit.exception !== e.exception)
            report_mismatch(e.name, "exception", word_t'(e.exception), word_t'(commit.exception));
        if (e.exception && commit.epc !== e.pc) report_mismatch(e.name, "epc", e.pc, commit.epc);
    endtask

    task automatic wait_commit(output bit got);
        int cycles;
        got    = 1'b0;
        cycles = 0;
        while (!got && cycles < commit_timeout) begin
            @(negedge CLK);                     // commit is stable mid-cycle
            cycles++;
            if (commit.valid) got = 1'b1;
        end
    endtask

    initial begin : halt_driver
        int cycles;
        int stretch;
        cycles = 0;
        @(posedge CLK);
        while (!halt_due() && cycles < halt_timeout) begin
            @(posedge CLK);
            cycles++;
        end
        if (!halt_due()) begin
            $display("halt_freeze records never came up, halt was not applied");
            errors++;
        end else begin
            stretch = 4 + ($urandom % 9);       // 4..12 frozen cycles
            halt <= 1'b1;
            repeat (stretch) @(posedge CLK);
            halt <= 1'b0;
        end
    end

    initial begin : main_flow
        bit got;
        bit timed_out;
        void'($urandom(20));
        rst_n       = 1'b0;
        halt        = 1'b0;
        imem_busy   = 1'b0;
        dmem_busy   = 1'b0;
        halt_prev   = 1'b0;
        rec_idx     = 0;
        errors      = 0;
        checks      = 0;
        halt_cycles = 0;
        timed_out   = 1'b0;
        for (int i = 0; i < 256; i++) imem[i] = {i[24:0], 7'b0000000};   // opcode 0 is illegal
        for (int i = 0; i < 64; i++) dmem[i] = '0;
        load_golden();
        if (golden.size() == 0) begin
            $display("no commit records read from the golden trace");
            errors++;
        end
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        checks++;
        if (imem_ren !== 1'b0 || dmem_ren !== 1'b0
                || dmem_wen !== 1'b0 || commit.valid !== 1'b0) begin
            $display("request or commit outputs not cleared during reset");
            errors++;
        end
        @(posedge CLK);
        rst_n <= 1'b1;                          // 5 cycles in reset
        while (rec_idx < golden.size() && !timed_out) begin
            wait_commit(got);
            if (!got) begin
                $display("timeout: no retirement within %0d cycles, waiting for record %0d (%0s)",
                         commit_timeout, rec_idx, golden[rec_idx].name);
                errors++;
                timed_out = 1'b1;
            end else begin
                compare_commit(golden[rec_idx]);
                rec_idx++;
            end
        end
        if (halt_cycles == 0) begin
            $display("halt was never held during the run");
            errors++;
        end
        $display("checks: %0d run, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: test/golden_trace.txt
# I <byte address> <instruction word>, both hex
# C <test> <pc hex> <rd decimal> <wdata hex> <has_write> <exception>
I 00000000 00500093
I 00000004 00708113
I 00000008 002081b3
I 0000000c 40118233
I 00000010 404082b3
I 00000014 04000313
I 00000018 00532023
I 0000001c 00032383
I 00000020 00138433
I 00000024 00340493
I 00000028 00108663
I 00000034 00109463
I 00000038 00c005ef
I 00000044 00158613
I 00000048 00260693
I 0000004c 00c68733
I 00000050 401707b3
I 00000054 fff78813
I 00000058 ffffffff
I 00000100 00900893
I 00000104 01188933
I 00000108 0000006f

C alu_chain 00000000 1 00000005 1 0
C alu_chain 00000004 2 0000000c 1 0
C alu_chain 00000008 3 00000011 1 0
C alu_chain 0000000c 4 0000000c 1 0
C alu_chain 00000010 5 fffffff9 1 0
C load_use 00000014 6 00000040 1 0
C load_use 00000018 0 00000000 0 0
C load_use 0000001c 7 fffffff9 1 0
C load_use 00000020 8 fffffffe 1 0
C load_use 00000024 9 00000001 1 0
C branch_redirect 00000028 0 00000000 0 0
C branch_redirect 00000034 0 00000000 0 0
C branch_redirect 00000038 11 0000003c 1 0
C branch_redirect 00000044 12 0000003d 1 0
C halt_freeze 00000048 13 0000003f 1 0
C halt_freeze 0000004c 14 0000007c 1 0
C halt_freeze 00000050 15 00000077 1 0
C halt_freeze 00000054 16 00000076 1 0
C illegal_trap 00000058 0 00000000 0 1
C illegal_trap 00000100 17 00000009 1 0
C illegal_trap 00000104 18 00000012 1 0
C illegal_trap 00000108 0 00000000 0 0

// File: project.f
hw/pipe_pkg.sv
hw/fetch_stage.sv
hw/insn_queue.sv
hw/exec_mem_stage.sv
hw/hazard_unit.sv
hw/rv_pipe_top.sv
test/rv_pipe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the pipeline testbench with verilator, run it, pass only on the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
    --top-module rv_pipe_tb -f project.f -o rv_pipe_sim

output=$(./obj_dir/rv_pipe_sim)
echo "$output"

if grep -q "^ALL CHECKS PASSED$" <<< "$output"; then
    exit 0
fi
exit 1
